/* hw/boot_rom_image.svh */
// ------------------------------------------------
// Fixed boot ROM contents, 16 words of 64 bits
// ------------------------------------------------

// Lower half of a code word executes first
localparam logic [63:0] BOOT_ROM_IMAGE [16] = '{
    // csrr a0, mhartid / auipc t0, 0
    64'h0000_0297_f140_2573,
    // addi a1, t0, 32 / ld t0, 24(t0)
    64'h0182_b283_0202_8593,
    // jr t0, upper half unused
    64'h0000_0000_0002_8067,
    // Jump target, start of main memory
    64'h0000_0000_8000_0000,
    // Parking loop for a core that returns
    64'h1050_0073_1050_0073,
    64'hffdf_f06f_1050_0073,
    // Small descriptor blob behind the code
    64'h3800_0000_edfe_0dd0,
    64'h4800_0000_2800_0000,
    64'h1100_0000_1000_0000,
    64'h0000_0000_0000_0000,
    64'h0000_0000_2000_0000,
    64'h0000_0000_0100_0000,
    64'h0200_0000_0000_0000,
    64'h0000_0001_0000_0003,
    64'h5a5a_a5a5_c3c3_3c3c,
    64'hdead_beef_0bad_f00d
};

/* hw/soc_map_pkg.sv */
// ------------------------------------------------
// System memory map, bus widths and the
// response target selector
// ------------------------------------------------

package soc_map_pkg;

    // ------------------------------------------------
    // Bus geometry
    // ------------------------------------------------
    localparam int unsigned AddrWidth = 32;
    localparam int unsigned DataWidth = 64;
    localparam int unsigned StrbWidth = DataWidth / 8;

    // ------------------------------------------------
    // Address map
    // ------------------------------------------------
    // Boot ROM, length counted in 64-bit words
    localparam logic [AddrWidth-1:0] RomBase   = 32'h0001_0000;
    localparam int unsigned          RomLength = 16;

    // Core-local interruptor, window length lives with its registers
    localparam logic [AddrWidth-1:0] ClintBase = 32'h0200_0000;

    // Main memory, size set by the SRAM depth
    localparam logic [AddrWidth-1:0] DramBase  = 32'h8000_0000;

    // ------------------------------------------------
    // Target selected by the decoder
    // ------------------------------------------------
    // TGT_NONE marks an error response
    typedef enum logic [1:0] {
        TGT_ROM   = 2'd0,
        TGT_CLINT = 2'd1,
        TGT_DRAM  = 2'd2,
        TGT_NONE  = 2'd3
    } target_e;

endpackage

/* hw/clint_pkg.sv */
// ------------------------------------------------
// CLINT register offsets and window length
// ------------------------------------------------

package clint_pkg;

    // Size of the CLINT address window in bytes
    localparam logic [31:0] ClintLength = 32'h000C_0000;

    // Register offsets within the window, low 16 address bits
    typedef enum logic [15:0] {
        // Software interrupt pending, bit 0 only
        REG_MSIP     = 16'h0000,
        // Timer compare value
        REG_MTIMECMP = 16'h4000,
        // Real-time counter
        REG_MTIME    = 16'hBFF8
    } clint_reg_e;

endpackage

/* hw/addr_decoder.sv */
// ------------------------------------------------
// Address decoder with registered target select
// and response merge
// ------------------------------------------------

`timescale 1ns/1ps

module addr_decoder
    import soc_map_pkg::*;
    import clint_pkg::*;
#(
    parameter int unsigned NUM_WORDS = 1024
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 req_i,
    input  logic                 we_i,
    input  logic [AddrWidth-1:0] addr_i,
    input  logic [DataWidth-1:0] rom_rdata_i,
    input  logic [DataWidth-1:0] clint_rdata_i,
    input  logic [DataWidth-1:0] dram_rdata_i,
    output logic                 rom_req_o,
    output logic                 clint_req_o,
    output logic                 dram_req_o,
    output logic                 rvalid_o,
    output logic [DataWidth-1:0] rdata_o,
    output logic                 err_o
);

    // Exclusive window ends
    localparam logic [AddrWidth-1:0] RomEnd   = RomBase + RomLength * 8;
    localparam logic [AddrWidth-1:0] ClintEnd = ClintBase + ClintLength;
    localparam logic [AddrWidth-1:0] DramEnd  = DramBase + NUM_WORDS * 8;

    logic    in_rom;
    logic    in_clint;
    logic    in_dram;
    target_e sel;
    logic    rsp_valid_q;
    logic    rsp_we_q;
    target_e rsp_tgt_q;

    // ------------------------------------------------
    // Request stage
    // ------------------------------------------------
    assign in_rom   = (addr_i >= RomBase) && (addr_i < RomEnd);
    assign in_clint = (addr_i >= ClintBase) && (addr_i < ClintEnd);
    assign in_dram  = (addr_i >= DramBase) && (addr_i < DramEnd);

    // ROM is read-only, a write there is an error
    always_comb begin
        sel = TGT_NONE;
        if (in_rom && !we_i) begin
            sel = TGT_ROM;
        end else if (in_clint) begin
            sel = TGT_CLINT;
        end else if (in_dram) begin
            sel = TGT_DRAM;
        end
    end

    assign rom_req_o   = req_i && (sel == TGT_ROM);
    assign clint_req_o = req_i && (sel == TGT_CLINT);
    assign dram_req_o  = req_i && (sel == TGT_DRAM);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rsp_valid_q <= 1'b0;
            rsp_we_q    <= 1'b0;
            rsp_tgt_q   <= TGT_NONE;
        end else begin
            rsp_valid_q <= req_i;
            if (req_i) begin
                rsp_we_q  <= we_i;
                rsp_tgt_q <= sel;
            end
        end
    end

    // ------------------------------------------------
    // Response stage
    // ------------------------------------------------
    assign rvalid_o = rsp_valid_q;
    assign err_o    = rsp_valid_q && (rsp_tgt_q == TGT_NONE);

    // Writes and errors carry no data
    always_comb begin
        rdata_o = '0;
        if (rsp_valid_q && !rsp_we_q) begin
            case (rsp_tgt_q)
                TGT_ROM:   rdata_o = rom_rdata_i;
                TGT_CLINT: rdata_o = clint_rdata_i;
                TGT_DRAM:  rdata_o = dram_rdata_i;
                default:   rdata_o = '0;
            endcase
        end
    end

endmodule

/* hw/boot_rom.sv */
// ------------------------------------------------
// Boot ROM with registered read
// ------------------------------------------------

`timescale 1ns/1ps

module boot_rom
    import soc_map_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 req_i,
    input  logic [AddrWidth-1:0] addr_i,
    output logic [DataWidth-1:0] rdata_o
);

    `include "boot_rom_image.svh"

    // Word select within the 16-word image
    logic [3:0] word_idx;

    assign word_idx = addr_i[6:3];

    // Output holds the last word read between strobes
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_o <= BOOT_ROM_IMAGE[word_idx];
        end
    end

endmodule

/* hw/sram.sv */
// ------------------------------------------------
// Main memory, byte-enabled writes and
// registered reads
// ------------------------------------------------

`timescale 1ns/1ps

module sram
    import soc_map_pkg::*;
#(
    parameter int unsigned NUM_WORDS = 1024
) (
    input  logic                 clk_i,
    input  logic                 req_i,
    input  logic                 we_i,
    input  logic [AddrWidth-1:0] addr_i,
    input  logic [StrbWidth-1:0] be_i,
    input  logic [DataWidth-1:0] wdata_i,
    output logic [DataWidth-1:0] rdata_o
);

    localparam int unsigned ByteOffset = $clog2(StrbWidth);
    localparam int unsigned IdxWidth   = $clog2(NUM_WORDS);

    logic [DataWidth-1:0] mem_q [NUM_WORDS];
    logic [IdxWidth-1:0]  word_idx;

    // Bits above the index wrap the address around the array
    assign word_idx = addr_i[ByteOffset +: IdxWidth];

    // ------------------------------------------------
    // Memory array
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            if (we_i) begin
                for (int i = 0; i < StrbWidth; i++) begin
                    if (be_i[i]) begin
                        mem_q[word_idx][8*i +: 8] <= wdata_i[8*i +: 8];
                    end
                end
            end
            // Old contents on a write, dropped by the decoder
            rdata_o <= mem_q[word_idx];
        end
    end

endmodule

/* hw/clint.sv */
// ------------------------------------------------
// CLINT with real-time counter, timer compare
// and software interrupt registers
// ------------------------------------------------

`timescale 1ns/1ps

module clint
    import soc_map_pkg::*;
    import clint_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 rtc_i,
    input  logic                 req_i,
    input  logic                 we_i,
    input  logic [AddrWidth-1:0] addr_i,
    input  logic [StrbWidth-1:0] be_i,
    input  logic [DataWidth-1:0] wdata_i,
    output logic [DataWidth-1:0] rdata_o,
    output logic                 timer_irq_o,
    output logic                 ipi_o
);

    logic                 rtc_sync1_q;
    logic                 rtc_sync2_q;
    logic                 rtc_prev_q;
    logic                 rtc_rise;
    logic [DataWidth-1:0] mtime_q;
    logic [DataWidth-1:0] mtime_inc;
    logic [DataWidth-1:0] mtime_d;
    logic [DataWidth-1:0] mtimecmp_q;
    logic [DataWidth-1:0] mtimecmp_d;
    logic                 msip_q;
    logic                 msip_d;
    logic                 timer_irq_q;
    logic [DataWidth-1:0] rdata_d;
    logic                 wr_en;
    clint_reg_e           reg_sel;

    // Overlay the enabled bytes of a write onto a register value
    function automatic logic [DataWidth-1:0] merge_bytes(
        input logic [DataWidth-1:0] old_val,
        input logic [DataWidth-1:0] new_val,
        input logic [StrbWidth-1:0] be
    );
        logic [DataWidth-1:0] res;
        res = old_val;
        for (int i = 0; i < StrbWidth; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    // ------------------------------------------------
    // RTC synchronizer and edge detect
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rtc_sync1_q <= 1'b0;
            rtc_sync2_q <= 1'b0;
            rtc_prev_q  <= 1'b0;
        end else begin
            rtc_sync1_q <= rtc_i;
            rtc_sync2_q <= rtc_sync1_q;
            rtc_prev_q  <= rtc_sync2_q;
        end
    end

    // mtime steps on the third clock after the rtc edge
    assign rtc_rise  = rtc_sync2_q && !rtc_prev_q;
    assign mtime_inc = mtime_q + DataWidth'(rtc_rise);

    // ------------------------------------------------
    // Register writes
    // ------------------------------------------------
    assign reg_sel = clint_reg_e'(addr_i[15:0]);
    assign wr_en   = req_i && we_i;

    // A bus write to mtime overrides the tick for the enabled bytes
    always_comb begin
        mtime_d    = mtime_inc;
        mtimecmp_d = mtimecmp_q;
        msip_d     = msip_q;
        if (wr_en) begin
            case (reg_sel)
                REG_MSIP: begin
                    if (be_i[0]) begin
                        msip_d = wdata_i[0];
                    end
                end
                REG_MTIMECMP: mtimecmp_d = merge_bytes(mtimecmp_q, wdata_i, be_i);
                REG_MTIME:    mtime_d    = merge_bytes(mtime_inc, wdata_i, be_i);
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mtime_q     <= '0;
            mtimecmp_q  <= '1;
            msip_q      <= 1'b0;
            timer_irq_q <= 1'b0;
        end else begin
            mtime_q     <= mtime_d;
            mtimecmp_q  <= mtimecmp_d;
            msip_q      <= msip_d;
            timer_irq_q <= (mtime_q >= mtimecmp_q);
        end
    end

    // ------------------------------------------------
    // Read data and interrupts
    // ------------------------------------------------
    always_comb begin
        case (reg_sel)
            REG_MSIP:     rdata_d = DataWidth'(msip_q);
            REG_MTIMECMP: rdata_d = mtimecmp_q;
            REG_MTIME:    rdata_d = mtime_q;
            default:      rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_o <= rdata_d;
        end
    end

    assign timer_irq_o = timer_irq_q;
    assign ipi_o       = msip_q;

endmodule

/* hw/soc_harness_top.sv */
// ------------------------------------------------
// System harness top, decoder plus ROM, SRAM
// and CLINT targets
// ------------------------------------------------

`timescale 1ns/1ps

module soc_harness_top
    import soc_map_pkg::*;
#(
    parameter int unsigned NUM_WORDS = 1024
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 rtc_i,
    input  logic                 req_i,
    input  logic                 we_i,
    input  logic [AddrWidth-1:0] addr_i,
    input  logic [StrbWidth-1:0] be_i,
    input  logic [DataWidth-1:0] wdata_i,
    output logic                 rvalid_o,
    output logic                 err_o,
    output logic [DataWidth-1:0] rdata_o,
    output logic                 timer_irq_o,
    output logic                 ipi_o
);

    // Per-target strobes and read data
    logic                 rom_req;
    logic                 clint_req;
    logic                 dram_req;
    logic [DataWidth-1:0] rom_rdata;
    logic [DataWidth-1:0] clint_rdata;
    logic [DataWidth-1:0] dram_rdata;

    addr_decoder #(
        .NUM_WORDS ( NUM_WORDS )
    ) addr_decoder_inst (
        .clk_i         ( clk_i       ),
        .rst_i         ( rst_i       ),
        .req_i         ( req_i       ),
        .we_i          ( we_i        ),
        .addr_i        ( addr_i      ),
        .rom_rdata_i   ( rom_rdata   ),
        .clint_rdata_i ( clint_rdata ),
        .dram_rdata_i  ( dram_rdata  ),
        .rom_req_o     ( rom_req     ),
        .clint_req_o   ( clint_req   ),
        .dram_req_o    ( dram_req    ),
        .rvalid_o      ( rvalid_o    ),
        .rdata_o       ( rdata_o     ),
        .err_o         ( err_o       )
    );

    boot_rom boot_rom_inst (
        .clk_i   ( clk_i     ),
        .req_i   ( rom_req   ),
        .addr_i  ( addr_i    ),
        .rdata_o ( rom_rdata )
    );

    sram #(
        .NUM_WORDS ( NUM_WORDS )
    ) sram_inst (
        .clk_i   ( clk_i      ),
        .req_i   ( dram_req   ),
        .we_i    ( we_i       ),
        .addr_i  ( addr_i     ),
        .be_i    ( be_i       ),
        .wdata_i ( wdata_i    ),
        .rdata_o ( dram_rdata )
    );

    clint clint_inst (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .rtc_i       ( rtc_i       ),
        .req_i       ( clint_req   ),
        .we_i        ( we_i        ),
        .addr_i      ( addr_i      ),
        .be_i        ( be_i        ),
        .wdata_i     ( wdata_i     ),
        .rdata_o     ( clint_rdata ),
        .timer_irq_o ( timer_irq_o ),
        .ipi_o       ( ipi_o       )
    );

endmodule

/* verification/tb_soc_harness.sv */
// ------------------------------------------------
// Testbench for the system harness with a reference
// model and queued response checks
// ------------------------------------------------

`timescale 1ns/1ps

module tb_soc_harness
    import soc_map_pkg::*;
    import clint_pkg::*;
();

    `include "boot_rom_image.svh"

    localparam int unsigned TbWords       = 1024;
    localparam int unsigned TimeoutCycles = 20000;
    localparam int unsigned FillWords     = 64;
    localparam int unsigned NumWrites     = 500;
    localparam int unsigned NumReads      = 300;
    localparam int unsigned RtcTicks      = 5;
    localparam logic [31:0] Seed          = 32'h707b6254;

    // One address per hole in the map including just past each window end
    localparam logic [AddrWidth-1:0] BadAddrs [5] = '{
        32'h0000_0000, 32'h0001_0080, 32'h020C_0000, 32'h8000_2000, 32'hFFFF_FFF8
    };

    logic                 clk_i;
    logic                 rst_i;
    logic                 rtc_i;
    logic                 req_i;
    logic                 we_i;
    logic [AddrWidth-1:0] addr_i;
    logic [StrbWidth-1:0] be_i;
    logic [DataWidth-1:0] wdata_i;
    logic                 rvalid_o;
    logic                 err_o;
    logic [DataWidth-1:0] rdata_o;
    logic                 timer_irq_o;
    logic                 ipi_o;

    // Reference model state
    logic [DataWidth-1:0] model_mem [TbWords];
    logic [DataWidth-1:0] model_mtime;
    logic [DataWidth-1:0] model_mtimecmp;
    logic                 model_msip;
    logic [31:0]          lfsr_state;
    logic [DataWidth:0]   exp_q [$];
    logic [DataWidth:0]   exp_rsp;
    logic                 rsp_due = 1'b0;
    int unsigned          cycle_cnt = 0;

    soc_harness_top #(
        .NUM_WORDS ( TbWords )
    ) soc_harness_top_inst (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .rtc_i       ( rtc_i       ),
        .req_i       ( req_i       ),
        .we_i        ( we_i        ),
        .addr_i      ( addr_i      ),
        .be_i        ( be_i        ),
        .wdata_i     ( wdata_i     ),
        .rvalid_o    ( rvalid_o    ),
        .err_o       ( err_o       ),
        .rdata_o     ( rdata_o     ),
        .timer_irq_o ( timer_irq_o ),
        .ipi_o       ( ipi_o       )
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // ------------------------------------------------
    // Random source and address map helpers
    // ------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic in_rom(input logic [AddrWidth-1:0] a);
        return (a >= RomBase) && (a < RomBase + RomLength * 8);
    endfunction

    function automatic logic in_clint(input logic [AddrWidth-1:0] a);
        return (a >= ClintBase) && (a < ClintBase + ClintLength);
    endfunction

    function automatic logic in_dram(input logic [AddrWidth-1:0] a);
        return (a >= DramBase) && (a < DramBase + TbWords * 8);
    endfunction

    // Byte lanes with their enable set take the new value
    function automatic logic [DataWidth-1:0] apply_strobes(
        input logic [DataWidth-1:0] old_val,
        input logic [DataWidth-1:0] new_val,
        input logic [StrbWidth-1:0] be
    );
        logic [DataWidth-1:0] mask;
        mask = '0;
        for (int i = 0; i < StrbWidth; i++) begin
            mask[8*i +: 8] = {8{be[i]}};
        end
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    // ------------------------------------------------
    // Reference model
    // ------------------------------------------------
    // Expected {err, rdata} for a request against the current model state
    function automatic logic [DataWidth:0] ref_response(
        input logic                 we,
        input logic [AddrWidth-1:0] addr
    );
        logic [AddrWidth-1:0] offs;
        offs = '0;
        if (we) begin
            // Writes return no data and fail only for ROM writes and holes
            return {!(in_clint(addr) || in_dram(addr)), 64'h0};
        end
        if (in_rom(addr)) begin
            offs = addr - RomBase;
            return {1'b0, BOOT_ROM_IMAGE[offs >> 3]};
        end
        if (in_clint(addr)) begin
            case (addr[15:0])
                REG_MSIP:     return {1'b0, 63'h0, model_msip};
                REG_MTIMECMP: return {1'b0, model_mtimecmp};
                REG_MTIME:    return {1'b0, model_mtime};
                default:      return {1'b0, 64'h0};
            endcase
        end
        if (in_dram(addr)) begin
            offs = addr - DramBase;
            return {1'b0, model_mem[offs >> 3]};
        end
        return {1'b1, 64'h0};
    endfunction

    task automatic model_write(
        input logic [AddrWidth-1:0] addr,
        input logic [StrbWidth-1:0] be,
        input logic [DataWidth-1:0] wdata
    );
        logic [AddrWidth-1:0] offs;
        offs = addr - DramBase;
        if (in_dram(addr)) begin
            model_mem[offs >> 3] = apply_strobes(model_mem[offs >> 3], wdata, be);
        end else if (in_clint(addr)) begin
            case (addr[15:0])
                REG_MSIP:     model_msip = be[0] ? wdata[0] : model_msip;
                REG_MTIMECMP: model_mtimecmp = apply_strobes(model_mtimecmp, wdata, be);
                REG_MTIME:    model_mtime = apply_strobes(model_mtime, wdata, be);
                default: ;
            endcase
        end
    endtask

    // ------------------------------------------------
    // Checking and bus driving
    // ------------------------------------------------
    task automatic check_value(
        input logic [DataWidth-1:0] actual,
        input logic [DataWidth-1:0] expected,
        input string                what
    );
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s, got 0x%0h expected 0x%0h",
                     $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Leaves req_i high so back-to-back calls give one request per cycle
    task automatic issue(
        input logic                 we,
        input logic [AddrWidth-1:0] addr,
        input logic [StrbWidth-1:0] be,
        input logic [DataWidth-1:0] wdata
    );
        @(posedge clk_i);
        #5;
        req_i   = 1'b1;
        we_i    = we;
        addr_i  = addr;
        be_i    = be;
        wdata_i = wdata;
        exp_q.push_back(ref_response(we, addr));
        if (we) begin
            model_write(addr, be, wdata);
        end
    endtask

    task automatic bus_idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #5;
            req_i = 1'b0;
            we_i  = 1'b0;
        end
    endtask

    // Each pulse is high 4 cycles and low 4 cycles
    task automatic rtc_pulses(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #5;
            rtc_i = 1'b1;
            repeat (4) @(posedge clk_i);
            #5;
            rtc_i = 1'b0;
            repeat (3) @(posedge clk_i);
            model_mtime = model_mtime + 1;
        end
    endtask

    // Response due one cycle after each request seen on the bus
    always @(negedge clk_i) begin
        if (rsp_due) begin
            check_value(rvalid_o, 1, "rvalid_o missing one cycle after request");
            check_value(exp_q.size() != 0, 1, "response with no request queued");
            exp_rsp = exp_q.pop_front();
            check_value(err_o, exp_rsp[DataWidth], "err_o");
            check_value(rdata_o, exp_rsp[DataWidth-1:0], "rdata_o");
        end else begin
            check_value(rvalid_o, 0, "rvalid_o without a request");
        end
        rsp_due = req_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TimeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------------------------
    // Stimulus
    // ------------------------------------------------
    initial begin
        rst_i          = 1'b1;
        rtc_i          = 1'b0;
        req_i          = 1'b0;
        we_i           = 1'b0;
        addr_i         = '0;
        be_i           = '0;
        wdata_i        = '0;
        lfsr_state     = Seed;
        model_mtime    = '0;
        model_mtimecmp = '1;
        model_msip     = 1'b0;
        repeat (16) @(posedge clk_i);
        #5;
        rst_i = 1'b0;

        @(negedge clk_i);
        check_value(rvalid_o, 0, "rvalid_o after reset");
        check_value(err_o, 0, "err_o after reset");
        check_value(timer_irq_o, 0, "timer_irq_o after reset");
        check_value(ipi_o, 0, "ipi_o after reset");
        issue(1'b0, ClintBase + REG_MTIME, '1, '0);
        issue(1'b0, ClintBase + REG_MTIMECMP, '1, '0);
        bus_idle(2);

        // Boot ROM reads followed by a write that must fail
        for (int i = 0; i < RomLength; i++) begin
            issue(1'b0, RomBase + i * 8, '1, '0);
        end
        issue(1'b1, RomBase + 8, '1, 64'h0123_4567_89ab_cdef);
        bus_idle(2);

        // Full-word fill so every read hits known data
        for (int i = 0; i < FillWords; i++) begin
            issue(1'b1, DramBase + i * 8, '1, rand_bits(64));
        end
        for (int i = 0; i < NumWrites; i++) begin
            issue(1'b1, DramBase + rand_bits(6) * 8, rand_bits(8), rand_bits(64));
        end
        for (int i = 0; i < NumReads; i++) begin
            issue(1'b0, DramBase + rand_bits(6) * 8, '1, '0);
        end
        bus_idle(2);

        for (int i = 0; i < 5; i++) begin
            issue(1'b0, BadAddrs[i], '1, '0);
            issue(1'b1, BadAddrs[i], '1, rand_bits(64));
        end
        bus_idle(2);

        // Software interrupt set and clear
        issue(1'b1, ClintBase + REG_MSIP, 8'h01, 64'h1);
        issue(1'b0, ClintBase + REG_MSIP, '1, '0);
        bus_idle(1);
        @(negedge clk_i);
        check_value(ipi_o, 1, "ipi_o after msip set");
        issue(1'b1, ClintBase + REG_MSIP, 8'h01, 64'h0);
        issue(1'b0, ClintBase + REG_MSIP, '1, '0);
        bus_idle(1);
        @(negedge clk_i);
        check_value(ipi_o, 0, "ipi_o after msip clear");

        // Timer from counted rtc edges
        rtc_pulses(RtcTicks);
        issue(1'b0, ClintBase + REG_MTIME, '1, '0);
        issue(1'b1, ClintBase + REG_MTIMECMP, '1, RtcTicks + 3);
        bus_idle(4);
        @(negedge clk_i);
        check_value(timer_irq_o, 0, "timer_irq_o below compare");
        rtc_pulses(3);
        @(negedge clk_i);
        check_value(timer_irq_o, 1, "timer_irq_o at compare");
        issue(1'b0, ClintBase + REG_MTIME, '1, '0);
        bus_idle(4);

        if (exp_q.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Responses still outstanding at the end: %0d", exp_q.size());
            $display("Regression failed");
            $fatal(1, "missing responses");
        end
    end

endmodule

/* flist.f */
+incdir+hw
hw/soc_map_pkg.sv
hw/clint_pkg.sv
hw/addr_decoder.sv
hw/boot_rom.sv
hw/sram.sv
hw/clint.sv
hw/soc_harness_top.sv
verification/tb_soc_harness.sv

/* Bender.yml */
package:
  name: soc_harness

sources:
  # Synthesizable sources in compile order
  - include_dirs:
      - hw
    files:
      - hw/soc_map_pkg.sv
      - hw/clint_pkg.sv
      - hw/addr_decoder.sv
      - hw/boot_rom.sv
      - hw/sram.sv
      - hw/clint.sv
      - hw/soc_harness_top.sv

  # Testbench, top module tb_soc_harness
  - target: test
    include_dirs:
      - hw
    files:
      - verification/tb_soc_harness.sv
